/* src/ecc_pkg.sv */
`default_nettype none

package ecc_pkg;

    localparam int WORD_W = 32;
    localparam int KEY_W = 16;                  // explicit key bits, msb of k implied
    localparam int KEY_CNT_W = $clog2(KEY_W);

    localparam int DBL_STEPS = 12;
    localparam int ADD_STEPS = 9;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [KEY_W-1:0] key_t;
    typedef logic [KEY_CNT_W-1:0] key_cnt_t;

    // arithmetic unit opcodes
    typedef enum logic [1:0] {
        GF_ADD = 2'd0,
        GF_SUB = 2'd1,
        GF_MUL = 2'd2,
        GF_DIV = 2'd3
    } gf_op_t;

    typedef enum logic [2:0] {
        SEL_X1 = 3'd0,                          // accumulator
        SEL_Y1 = 3'd1,
        SEL_X2 = 3'd2,                          // base point
        SEL_Y2 = 3'd3,
        SEL_T1 = 3'd4,
        SEL_T2 = 3'd5,
        SEL_T3 = 3'd6,
        SEL_CA = 3'd7                           // curve a
    } reg_sel_t;

    typedef struct packed {
        gf_op_t   op;
        reg_sel_t src_a;
        reg_sel_t src_b;
        reg_sel_t dst;
    } micro_op_t;

endpackage

`default_nettype wire

/* src/seq_rf_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface seq_rf_if
    import ecc_pkg::*;
();

    logic      load;                            // latch input point and a
    micro_op_t uop;
    logic      wr_en;                           // result write strobe
    logic      commit;                          // T3 -> X1

    modport sequencer (
        output load,
        output uop,
        output wr_en,
        output commit
    );

    modport regfile (
        input load,
        input uop,
        input wr_en,
        input commit
    );

endinterface

`default_nettype wire

/* src/key_shifter.sv */
`timescale 1ns/1ns
`default_nettype none

module key_shifter
    import ecc_pkg::*;
(
    input  logic i_clk,
    input  logic i_reset,
    input  logic i_load,
    input  logic i_shift,
    input  key_t i_key,
    output logic o_bit,
    output logic o_last
);

    key_t     key_q;
    key_cnt_t bit_cnt;                          // bits left after the current one

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            key_q   <= '0;
            bit_cnt <= '0;
        end
        else if (i_load)
        begin
            key_q   <= i_key;
            bit_cnt <= key_cnt_t'(KEY_W - 1);
        end
        else if (i_shift)
        begin
            key_q   <= {key_q[KEY_W-2:0], 1'b0}; // next bit to msb
            bit_cnt <= bit_cnt - 1'b1;
        end
    end

    assign o_bit  = key_q[KEY_W-1];
    assign o_last = (bit_cnt == '0);

endmodule

`default_nettype wire

/* src/point_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module point_sequencer
    import ecc_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_reset,
    input  logic        i_start,
    input  logic        i_bit,
    input  logic        i_last,
    output logic        o_key_load,
    output logic        o_key_shift,
    seq_rf_if.sequencer rf,
    output logic        o_gf_req,
    input  logic        i_gf_done,
    output logic        o_busy,
    output logic        o_done
);

    typedef enum logic [2:0] {ST_IDLE, ST_LOAD, ST_ISSUE, ST_WAIT, ST_GAP} state_t;

    state_t     state;
    logic       is_add;                         // walking the addition table
    logic [3:0] step;
    logic       done_q;
    logic       op_done;
    logic       seq_end;

    // point doubling, lambda = (3*x1^2 + a) / (2*y1)
    function automatic micro_op_t dbl_uop(input logic [3:0] idx);
        case (idx)
            4'd0:    return micro_op_t'{GF_MUL, SEL_X1, SEL_X1, SEL_T1};
            4'd1:    return micro_op_t'{GF_ADD, SEL_T1, SEL_T1, SEL_T2};
            4'd2:    return micro_op_t'{GF_ADD, SEL_T2, SEL_T1, SEL_T1};
            4'd3:    return micro_op_t'{GF_ADD, SEL_T1, SEL_CA, SEL_T1};
            4'd4:    return micro_op_t'{GF_ADD, SEL_Y1, SEL_Y1, SEL_T2};
            4'd5:    return micro_op_t'{GF_DIV, SEL_T1, SEL_T2, SEL_T1};
            4'd6:    return micro_op_t'{GF_MUL, SEL_T1, SEL_T1, SEL_T2};
            4'd7:    return micro_op_t'{GF_SUB, SEL_T2, SEL_X1, SEL_T2};
            4'd8:    return micro_op_t'{GF_SUB, SEL_T2, SEL_X1, SEL_T3}; // new x
            4'd9:    return micro_op_t'{GF_SUB, SEL_X1, SEL_T3, SEL_T2};
            4'd10:   return micro_op_t'{GF_MUL, SEL_T1, SEL_T2, SEL_T2};
            default: return micro_op_t'{GF_SUB, SEL_T2, SEL_Y1, SEL_Y1}; // new y
        endcase
    endfunction

    // point addition, lambda = (y2 - y1) / (x2 - x1)
    function automatic micro_op_t add_uop(input logic [3:0] idx);
        case (idx)
            4'd0:    return micro_op_t'{GF_SUB, SEL_X2, SEL_X1, SEL_T1};
            4'd1:    return micro_op_t'{GF_SUB, SEL_Y2, SEL_Y1, SEL_T2};
            4'd2:    return micro_op_t'{GF_DIV, SEL_T2, SEL_T1, SEL_T1};
            4'd3:    return micro_op_t'{GF_MUL, SEL_T1, SEL_T1, SEL_T2};
            4'd4:    return micro_op_t'{GF_SUB, SEL_T2, SEL_X1, SEL_T2};
            4'd5:    return micro_op_t'{GF_SUB, SEL_T2, SEL_X2, SEL_T3};
            4'd6:    return micro_op_t'{GF_SUB, SEL_X1, SEL_T3, SEL_T2};
            4'd7:    return micro_op_t'{GF_MUL, SEL_T1, SEL_T2, SEL_T2};
            default: return micro_op_t'{GF_SUB, SEL_T2, SEL_Y1, SEL_Y1};
        endcase
    endfunction

    assign o_gf_req = (state == ST_ISSUE) || (state == ST_WAIT);
    assign op_done  = o_gf_req && i_gf_done;
    assign seq_end  = op_done &&
                      (step == (is_add ? 4'(ADD_STEPS - 1) : 4'(DBL_STEPS - 1)));

    assign rf.load   = (state == ST_LOAD);
    assign rf.uop    = is_add ? add_uop(step) : dbl_uop(step);
    assign rf.wr_en  = op_done;
    assign rf.commit = seq_end;

    assign o_key_load  = (state == ST_IDLE) && i_start;
    assign o_key_shift = seq_end && !i_last && (is_add || !i_bit); // move to next bit
    assign o_busy      = (state != ST_IDLE);
    assign o_done      = done_q;

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            state  <= ST_IDLE;
            is_add <= 1'b0;
            step   <= '0;
            done_q <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            case (state)
                ST_IDLE:
                    if (i_start)
                        state <= ST_LOAD;
                ST_LOAD:
                begin
                    state  <= ST_ISSUE;
                    is_add <= 1'b0;
                    step   <= '0;
                end
                ST_ISSUE, ST_WAIT:
                    if (!i_gf_done)
                        state <= ST_WAIT;
                    else if (!seq_end)
                    begin
                        state <= ST_GAP;
                        step  <= step + 1'b1;
                    end
                    else
                    begin
                        step <= '0;
                        if (!is_add && i_bit)
                        begin
                            state  <= ST_GAP;
                            is_add <= 1'b1;
                        end
                        else if (i_last)
                        begin
                            state  <= ST_IDLE;
                            done_q <= 1'b1;
                        end
                        else
                        begin
                            state  <= ST_GAP;
                            is_add <= 1'b0;
                        end
                    end
                ST_GAP:
                    state <= ST_ISSUE;
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/point_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module point_regfile
    import ecc_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_reset,
    seq_rf_if.regfile rf,
    input  word_t     i_px,
    input  word_t     i_py,
    input  word_t     i_a,
    input  word_t     i_gf_result,
    output gf_op_t    o_gf_op,
    output word_t     o_gf_a,
    output word_t     o_gf_b,
    output word_t     o_rx,
    output word_t     o_ry
);

    word_t regs [8];                            // indexed by reg_sel_t

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            for (int i = 0; i < 8; i++)
                regs[i] <= '0;
        end
        else if (rf.load)
        begin
            regs[SEL_X1] <= i_px;               // accumulator starts at P
            regs[SEL_Y1] <= i_py;
            regs[SEL_X2] <= i_px;
            regs[SEL_Y2] <= i_py;
            regs[SEL_CA] <= i_a;
        end
        else
        begin
            if (rf.wr_en)
                regs[rf.uop.dst] <= i_gf_result;
            // last step of a sequence writes Y1, X1 comes from T3 here
            if (rf.commit)
                regs[SEL_X1] <= regs[SEL_T3];
        end
    end

    assign o_gf_op = rf.uop.op;
    assign o_gf_a  = regs[rf.uop.src_a];
    assign o_gf_b  = regs[rf.uop.src_b];

    assign o_rx = regs[SEL_X1];
    assign o_ry = regs[SEL_Y1];

endmodule

`default_nettype wire

/* src/ecc_point_mul.sv */
`timescale 1ns/1ns
`default_nettype none

module ecc_point_mul
    import ecc_pkg::*;
(
    input  logic   i_clk,
    input  logic   i_reset,
    input  logic   i_start,
    input  key_t   i_key,
    input  word_t  i_px,
    input  word_t  i_py,
    input  word_t  i_a,
    output logic   o_gf_req,
    output gf_op_t o_gf_op,
    output word_t  o_gf_a,
    output word_t  o_gf_b,
    input  logic   i_gf_done,
    input  word_t  i_gf_result,
    output word_t  o_rx,
    output word_t  o_ry,
    output logic   o_busy,
    output logic   o_done
);

    logic key_load;
    logic key_shift;
    logic key_bit;
    logic key_last;

    seq_rf_if rf_bus ();

    key_shifter u_key (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_load  (key_load),
        .i_shift (key_shift),
        .i_key   (i_key),
        .o_bit   (key_bit),
        .o_last  (key_last)
    );

    point_sequencer u_seq (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_start     (i_start),
        .i_bit       (key_bit),
        .i_last      (key_last),
        .o_key_load  (key_load),
        .o_key_shift (key_shift),
        .rf          (rf_bus.sequencer),
        .o_gf_req    (o_gf_req),
        .i_gf_done   (i_gf_done),
        .o_busy      (o_busy),
        .o_done      (o_done)
    );

    point_regfile u_rf (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .rf          (rf_bus.regfile),
        .i_px        (i_px),
        .i_py        (i_py),
        .i_a         (i_a),
        .i_gf_result (i_gf_result),
        .o_gf_op     (o_gf_op),
        .o_gf_a      (o_gf_a),
        .o_gf_b      (o_gf_b),
        .o_rx        (o_rx),
        .o_ry        (o_ry)
    );

endmodule

`default_nettype wire

/* test/ecc_point_mul_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

module ecc_point_mul_asserts
    import ecc_pkg::*;
(
    input logic   i_clk,
    input logic   i_reset,
    input logic   o_gf_req,
    input gf_op_t o_gf_op,
    input word_t  o_gf_a,
    input word_t  o_gf_b,
    input logic   i_gf_done,
    input logic   o_busy,
    input logic   o_done
);

    a_req_hold: assert property (@(posedge i_clk) disable iff (i_reset)
        o_gf_req && !i_gf_done |=>
            o_gf_req && $stable(o_gf_op) && $stable(o_gf_a) && $stable(o_gf_b))
        else $error("gf request or operands changed while waiting");

    a_req_drop: assert property (@(posedge i_clk) disable iff (i_reset)
        o_gf_req && i_gf_done |=> !o_gf_req)
        else $error("gf request still high after the done pulse");

    // single done pulse in the cycle busy falls
    a_done_busy: assert property (@(posedge i_clk) disable iff (i_reset)
        o_done == $fell(o_busy))
        else $error("done and busy falling not in the same cycle");

endmodule

`default_nettype wire

/* test/ecc_point_mul_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module ecc_point_mul_tb
    import ecc_pkg::*;
();

    localparam logic [63:0] PRIME = 64'd4294967291;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    localparam int unsigned TEST_CNT = 7;      // tests that run a key
    localparam int unsigned CYCLE_LIMIT = TEST_CNT * (12 * KEY_W + 9 * KEY_W) * 6 + 2000;

    logic   i_clk;
    logic   i_reset;
    logic   i_start;
    key_t   i_key;
    word_t  i_px;
    word_t  i_py;
    word_t  i_a;
    logic   o_gf_req;
    gf_op_t o_gf_op;
    word_t  o_gf_a;
    word_t  o_gf_b;
    logic   i_gf_done;
    word_t  i_gf_result;
    word_t  o_rx;
    word_t  o_ry;
    logic   o_busy;
    logic   o_done;

    logic [31:0] lfsr_state;
    int unsigned req_count;
    int unsigned cycle_cnt = 0;
    int unsigned err_cnt;
    int unsigned check_cnt;
    int unsigned test_cnt;

    ecc_point_mul ecc_point_mul_inst (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_start     (i_start),
        .i_key       (i_key),
        .i_px        (i_px),
        .i_py        (i_py),
        .i_a         (i_a),
        .o_gf_req    (o_gf_req),
        .o_gf_op     (o_gf_op),
        .o_gf_a      (o_gf_a),
        .o_gf_b      (o_gf_b),
        .i_gf_done   (i_gf_done),
        .i_gf_result (i_gf_result),
        .o_rx        (o_rx),
        .o_ry        (o_ry),
        .o_busy      (o_busy),
        .o_done      (o_done)
    );

    bind ecc_point_mul ecc_point_mul_asserts u_asserts (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .o_gf_req  (o_gf_req),
        .o_gf_op   (o_gf_op),
        .o_gf_a    (o_gf_a),
        .o_gf_b    (o_gf_b),
        .i_gf_done (i_gf_done),
        .o_busy    (o_busy),
        .o_done    (o_done)
    );

    always #10 i_clk = ~i_clk;

    always @(posedge i_clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == CYCLE_LIMIT)
        begin
            $display("timeout: the DUT did not finish within %0d cycles", cycle_cnt);
            $display("Result: FAILED");
            $finish;
        end
    end

    // one lfsr step per bit taken
    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
        end
        return v;
    endfunction

    function automatic logic [63:0] fadd(input logic [63:0] a, input logic [63:0] b);
        return ((a % PRIME) + (b % PRIME)) % PRIME;
    endfunction

    function automatic logic [63:0] fsub(input logic [63:0] a, input logic [63:0] b);
        return ((a % PRIME) + PRIME - (b % PRIME)) % PRIME;
    endfunction

    function automatic logic [63:0] fmul(input logic [63:0] a, input logic [63:0] b);
        return ((a % PRIME) * (b % PRIME)) % PRIME;   // both below 2^32
    endfunction

    // fermat inverse a^(p-2) with zero mapped to zero
    function automatic logic [63:0] finv(input logic [63:0] a);
        logic [63:0] r;
        logic [63:0] base;
        logic [63:0] e;
        r = 64'd1;
        base = a % PRIME;
        e = PRIME - 64'd2;
        while (e != 64'd0)
        begin
            if (e[0])
                r = fmul(r, base);
            base = fmul(base, base);
            e = e >> 1;
        end
        return r;
    endfunction

    function automatic word_t gf_compute(input gf_op_t op, input word_t a, input word_t b);
        logic [63:0] r;
        case (op)
            GF_ADD:  r = fadd({32'd0, a}, {32'd0, b});
            GF_SUB:  r = fsub({32'd0, a}, {32'd0, b});
            GF_MUL:  r = fmul({32'd0, a}, {32'd0, b});
            default: r = fmul({32'd0, a}, finv({32'd0, b}));
        endcase
        return r[31:0];
    endfunction

    // affine double-and-add with the leading one of k implied
    task automatic model_mul(input key_t key, input word_t px, input word_t py, input word_t ca,
                             output word_t rx, output word_t ry);
        logic [63:0] x;
        logic [63:0] y;
        logic [63:0] lam;
        logic [63:0] nx;
        x = {32'd0, px};
        y = {32'd0, py};
        for (int i = KEY_W - 1; i >= 0; i--)
        begin
            lam = fmul(fadd(fmul(64'd3, fmul(x, x)), {32'd0, ca}), finv(fadd(y, y)));
            nx  = fsub(fmul(lam, lam), fadd(x, x));
            y   = fsub(fmul(lam, fsub(x, nx)), y);
            x   = nx;
            if (key[i])
            begin
                lam = fmul(fsub({32'd0, py}, y), finv(fsub({32'd0, px}, x)));
                nx  = fsub(fsub(fmul(lam, lam), x), {32'd0, px});
                y   = fsub(fmul(lam, fsub(x, nx)), y);
                x   = nx;
            end
        end
        rx = x[31:0];
        ry = y[31:0];
    endtask

    // plays the arithmetic unit
    task automatic serve_requests();
        logic [31:0] bits;
        logic [1:0]  delay;
        forever
        begin
            @(posedge i_clk);
            i_gf_done <= 1'b0;
            if (o_gf_req && !i_gf_done)
            begin
                bits  = draw_bits(2);
                delay = bits[1:0];
                repeat (delay) @(posedge i_clk);
                i_gf_result <= gf_compute(o_gf_op, o_gf_a, o_gf_b);
                i_gf_done   <= 1'b1;
                req_count++;
            end
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        check_cnt++;
        if (act !== exp)
        begin
            err_cnt++;
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int unsigned exp, input int unsigned act);
        check_cnt++;
        if (act != exp)
        begin
            err_cnt++;
            $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        check_cnt++;
        if (act !== exp)
        begin
            err_cnt++;
            $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic report_test(input string name, input int unsigned errs_before);
        test_cnt++;
        $display("test %s: %s", name, (err_cnt == errs_before) ? "ok" : "errors");
    endtask

    task automatic test_reset_state();
        int unsigned errs_before;
        errs_before = err_cnt;
        @(posedge i_clk);
        check_bit("reset o_busy", 1'b0, o_busy);
        check_bit("reset o_done", 1'b0, o_done);
        check_bit("reset o_gf_req", 1'b0, o_gf_req);
        report_test("reset_state", errs_before);
    endtask

    task automatic test_mul(input string name, input key_t key, input word_t px,
                            input word_t py, input word_t ca, input logic restart);
        word_t       exp_x;
        word_t       exp_y;
        int unsigned first_req;
        int unsigned errs_before;
        errs_before = err_cnt;
        model_mul(key, px, py, ca, exp_x, exp_y);
        first_req = req_count;
        @(posedge i_clk);
        i_key   <= key;
        i_px    <= px;
        i_py    <= py;
        i_a     <= ca;
        i_start <= 1'b1;
        @(posedge i_clk);
        i_start <= 1'b0;
        if (restart)
        begin
            repeat (5) @(posedge i_clk);
            check_bit({name, " busy"}, 1'b1, o_busy);
            i_key   <= ~key;                // must not reach the running job
            i_px    <= ~px;
            i_start <= 1'b1;
            @(posedge i_clk);
            i_start <= 1'b0;
        end
        do
            @(posedge i_clk);
        while (!o_done);
        check_bit({name, " busy at done"}, 1'b0, o_busy);
        check_word({name, " rx"}, exp_x, o_rx);
        check_word({name, " ry"}, exp_y, o_ry);
        check_count({name, " requests"}, 12 * KEY_W + 9 * $countones(key), req_count - first_req);
        report_test(name, errs_before);
    endtask

    initial
    begin
        key_t  key;
        word_t px;
        word_t py;
        word_t ca;
        i_clk       = 1'b0;
        i_reset     = 1'b1;
        i_start     = 1'b0;
        i_key       = '0;
        i_px        = '0;
        i_py        = '0;
        i_a         = '0;
        i_gf_done   = 1'b0;
        i_gf_result = '0;
        lfsr_state  = 32'h4e64_8671;
        req_count   = 0;
        err_cnt     = 0;
        check_cnt   = 0;
        test_cnt    = 0;
        repeat (2) @(posedge i_clk);
        i_reset <= 1'b0;
        fork
            serve_requests();
        join_none
        test_reset_state();
        test_mul("key_zero", '0, 32'h1234_5678, 32'h0bad_cafe, 32'd3, 1'b0);
        test_mul("key_ones", '1, 32'h7654_3210, 32'h1357_9bdf, 32'd7, 1'b0);
        for (int t = 0; t < 4; t++)
        begin
            key = key_t'(draw_bits(KEY_W));
            px  = draw_bits(WORD_W);
            py  = draw_bits(WORD_W);
            ca  = draw_bits(WORD_W);
            test_mul($sformatf("random_%0d", t), key, px, py, ca, 1'b0);
        end
        test_mul("start_while_busy", 16'ha5c3, 32'h0f1e_2d3c, 32'h4b5a_6978, 32'd2, 1'b1);
        $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
src/ecc_pkg.sv
src/seq_rf_if.sv
src/key_shifter.sv
src/point_sequencer.sv
src/point_regfile.sv
src/ecc_point_mul.sv
test/ecc_point_mul_asserts.sv
test/ecc_point_mul_tb.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module ecc_point_mul_tb -o sim_tb
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
exit 0
